//--- design/mac_pkg.sv
/*
 * shared definitions of the RMII transmit MAC
 *   - tagged stream byte as buffered by the frame fifo
 *   - serializer FSM state encoding
 *   - Ethernet framing and CRC-32 constants
 */
package mac_pkg;

	// ------------------------------
	// stream byte
	// ------------------------------
	// sop / eop tags travel with every data byte
	typedef struct packed {
		logic       sop;
		logic       eop;
		logic [7:0] data;
	} mac_byte_t;

	// ------------------------------
	// serializer states
	// ------------------------------
	typedef enum logic [2:0] {
		TX_IDLE     = 3'd0,
		TX_PREAMBLE = 3'd1,
		TX_SFD      = 3'd2,
		TX_PAYLOAD  = 3'd3,
		TX_FCS      = 3'd4,
		TX_GAP      = 3'd5
	} tx_state_e;

	// ------------------------------
	// framing
	// ------------------------------
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE      = 8'hD5;
	// preamble bytes ahead of the start-frame byte
	localparam int         PREAMBLE_LEN  = 7;
	// inter-frame gap in byte times
	localparam int         IPG_BYTES     = 12;

	// reflected CRC-32 (IEEE 802.3)
	localparam logic [31:0] CRC_POLY_REFL = 32'hEDB88320;
	localparam logic [31:0] CRC_INIT      = 32'hFFFFFFFF;

endpackage

//--- design/mac_frame_fifo.sv
/*
 * synchronous frame buffer
 *   - circular store of tagged stream bytes, show-ahead read
 *   - count of complete frames held (eop tags in, eop tags out)
 *   - writes into a full buffer are dropped and flagged
 */
`timescale 1ns/1ps

module mac_frame_fifo #(
	parameter int FIFO_DEPTH = 2048
) (
	input  logic              i_clk,
	input  logic              i_rst_n,

	input  logic              i_wr_en,
	input  mac_pkg::mac_byte_t i_wr_byte,

	input  logic              i_rd_en,
	output mac_pkg::mac_byte_t o_rd_byte,

	output logic              o_frame_ready,
	output logic              o_overflow
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	mac_pkg::mac_byte_t r_mem [FIFO_DEPTH];

	logic [PTR_W-1:0] r_wr_ptr;
	logic [PTR_W-1:0] r_rd_ptr;
	logic [CNT_W-1:0] r_byte_cnt;
	logic [CNT_W-1:0] r_frame_cnt;
	logic             r_overflow;

	logic             w_full;
	logic             w_wr_ok;
	logic             w_rd_ok;

	// ------------------------------
	// accept / release
	// ------------------------------
	assign w_full  = (r_byte_cnt == CNT_W'(FIFO_DEPTH));
	assign w_wr_ok = i_wr_en && !w_full;
	// reads on an empty buffer are ignored
	assign w_rd_ok = i_rd_en && (r_byte_cnt != '0);

	// byte storage
	always_ff @(posedge i_clk) begin
		if (w_wr_ok) begin
			r_mem[r_wr_ptr] <= i_wr_byte;
		end
	end

	// head byte straight from the array
	assign o_rd_byte = r_mem[r_rd_ptr];

	// ------------------------------
	// pointers and counters
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_wr_ptr    <= '0;
			r_rd_ptr    <= '0;
			r_byte_cnt  <= '0;
			r_frame_cnt <= '0;
			r_overflow  <= 1'b0;
		end else begin
			// explicit wrap for any depth
			if (w_wr_ok) begin
				r_wr_ptr <= (r_wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
			end
			if (w_rd_ok) begin
				r_rd_ptr <= (r_rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
			end

			// fill level
			case ({w_wr_ok, w_rd_ok})
				2'b10:   r_byte_cnt <= r_byte_cnt + 1'b1;
				2'b01:   r_byte_cnt <= r_byte_cnt - 1'b1;
				default: r_byte_cnt <= r_byte_cnt;
			endcase

			// complete frames held
			case ({w_wr_ok && i_wr_byte.eop, w_rd_ok && o_rd_byte.eop})
				2'b10:   r_frame_cnt <= r_frame_cnt + 1'b1;
				2'b01:   r_frame_cnt <= r_frame_cnt - 1'b1;
				default: r_frame_cnt <= r_frame_cnt;
			endcase

			// one pulse per dropped byte
			r_overflow <= i_wr_en && w_full;
		end
	end

	assign o_frame_ready = (r_frame_cnt != '0);
	assign o_overflow    = r_overflow;

endmodule

//--- design/mac_fcs_gen.sv
/*
 * frame check sequence generator
 *   - bytewise reflected CRC-32 over the write stream
 *   - reseeded on sop, inverted result queued at eop
 *   - small queue so finished FCS values wait for the serializer
 */
`timescale 1ns/1ps

module mac_fcs_gen #(
	parameter int FCS_DEPTH = 4
) (
	input  logic               i_clk,
	input  logic               i_rst_n,

	input  logic               i_wr_en,
	input  mac_pkg::mac_byte_t i_wr_byte,

	input  logic               i_pop,
	output logic [31:0]        o_fcs
);

	localparam int QPTR_W = $clog2(FCS_DEPTH);

	logic [31:0]       r_crc;
	logic [31:0]       r_queue [FCS_DEPTH];
	logic [QPTR_W-1:0] r_wr_ptr;
	logic [QPTR_W-1:0] r_rd_ptr;

	logic [31:0]       w_crc_base;
	logic [31:0]       w_crc_next;

	// fold one byte in lsb first with the reflected polynomial
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] dat);
		logic [31:0] c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			c = (c >> 1) ^ (mac_pkg::CRC_POLY_REFL & {32{c[0] ^ dat[i]}});
		end
		return c;
	endfunction

	// ------------------------------
	// running CRC
	// ------------------------------
	// first byte of a frame starts from all ones
	assign w_crc_base = i_wr_byte.sop ? mac_pkg::CRC_INIT : r_crc;
	assign w_crc_next = crc_byte(w_crc_base, i_wr_byte.data);

	// updated on every written byte
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			r_crc <= w_crc_next;
		end
	end

	// inverted final value into the queue at eop
	always_ff @(posedge i_clk) begin
		if (i_wr_en && i_wr_byte.eop) begin
			r_queue[r_wr_ptr] <= ~w_crc_next;
		end
	end

	// ------------------------------
	// queue pointers
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
		end else begin
			if (i_wr_en && i_wr_byte.eop) begin
				r_wr_ptr <= (r_wr_ptr == QPTR_W'(FCS_DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
			end
			if (i_pop) begin
				r_rd_ptr <= (r_rd_ptr == QPTR_W'(FCS_DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
			end
		end
	end

	// queue head is valid ahead of the pop
	assign o_fcs = r_queue[r_rd_ptr];

endmodule

//--- design/rmii_tx_serializer.sv
/*
 * RMII transmit serializer
 *   - framing FSM: preamble, SFD, payload, FCS, inter-frame gap
 *   - starts a frame only once it is fully buffered
 *   - one dibit per clock, low pair first, registered outputs
 */
`timescale 1ns/1ps

module rmii_tx_serializer (
	input  logic               i_clk,
	input  logic               i_rst_n,

	// frame fifo side
	input  logic               i_frame_ready,
	input  mac_pkg::mac_byte_t i_rd_byte,
	output logic               o_rd_en,

	// fcs queue side
	input  logic [31:0]        i_fcs,
	output logic               o_fcs_pop,

	// RMII transmit
	output logic               o_rmii_txen,
	output logic [1:0]         o_rmii_txd
);

	localparam int FCS_BYTES = 4;

	mac_pkg::tx_state_e r_state;
	logic [1:0]         r_phase;
	logic [3:0]         r_byte_cnt;
	logic [31:0]        r_fcs;
	logic               r_txen;
	logic [1:0]         r_txd;

	logic               w_byte_end;
	logic               w_on_wire;
	logic [7:0]         w_cur_byte;

	// last dibit of the current byte
	assign w_byte_end = (r_phase == 2'd3);

	// fifo read and fcs pop both land on phase three
	assign o_rd_en   = (r_state == mac_pkg::TX_PAYLOAD) && w_byte_end;
	assign o_fcs_pop = o_rd_en && i_rd_byte.eop;

	// ------------------------------
	// byte select
	// ------------------------------
	always_comb begin
		case (r_state)
			mac_pkg::TX_PREAMBLE: w_cur_byte = mac_pkg::PREAMBLE_BYTE;
			mac_pkg::TX_SFD:      w_cur_byte = mac_pkg::SFD_BYTE;
			mac_pkg::TX_PAYLOAD:  w_cur_byte = i_rd_byte.data;
			// fcs goes out lsb byte first
			mac_pkg::TX_FCS:      w_cur_byte = r_fcs[{r_byte_cnt[1:0], 3'b000} +: 8];
			default:              w_cur_byte = 8'h00;
		endcase
	end

	assign w_on_wire = (r_state == mac_pkg::TX_PREAMBLE) || (r_state == mac_pkg::TX_SFD) ||
	                   (r_state == mac_pkg::TX_PAYLOAD)  || (r_state == mac_pkg::TX_FCS);

	// ------------------------------
	// framing FSM
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_state    <= mac_pkg::TX_IDLE;
			r_phase    <= 2'd0;
			r_byte_cnt <= 4'd0;
		end else begin
			// phase free-runs while a frame or gap is in progress
			if (r_state != mac_pkg::TX_IDLE) begin
				r_phase <= r_phase + 1'b1;
			end

			case (r_state)
				mac_pkg::TX_IDLE: begin
					// whole frame buffered, go
					if (i_frame_ready) begin
						r_state    <= mac_pkg::TX_PREAMBLE;
						r_phase    <= 2'd0;
						r_byte_cnt <= 4'd0;
					end
				end
				mac_pkg::TX_PREAMBLE: begin
					if (w_byte_end) begin
						if (r_byte_cnt == 4'(mac_pkg::PREAMBLE_LEN - 1)) begin
							r_state    <= mac_pkg::TX_SFD;
							r_byte_cnt <= 4'd0;
						end else begin
							r_byte_cnt <= r_byte_cnt + 1'b1;
						end
					end
				end
				mac_pkg::TX_SFD: begin
					if (w_byte_end) begin
						r_state <= mac_pkg::TX_PAYLOAD;
					end
				end
				mac_pkg::TX_PAYLOAD: begin
					// eop byte is the last payload byte
					if (w_byte_end && i_rd_byte.eop) begin
						r_state    <= mac_pkg::TX_FCS;
						r_byte_cnt <= 4'd0;
					end
				end
				mac_pkg::TX_FCS: begin
					if (w_byte_end) begin
						if (r_byte_cnt == 4'(FCS_BYTES - 1)) begin
							r_state    <= mac_pkg::TX_GAP;
							r_byte_cnt <= 4'd0;
						end else begin
							r_byte_cnt <= r_byte_cnt + 1'b1;
						end
					end
				end
				mac_pkg::TX_GAP: begin
					if (w_byte_end) begin
						if (r_byte_cnt == 4'(mac_pkg::IPG_BYTES - 1)) begin
							r_state    <= mac_pkg::TX_IDLE;
							r_byte_cnt <= 4'd0;
						end else begin
							r_byte_cnt <= r_byte_cnt + 1'b1;
						end
					end
				end
				default: begin
					r_state <= mac_pkg::TX_IDLE;
				end
			endcase
		end
	end

	// capture queue head as it is popped
	always_ff @(posedge i_clk) begin
		if (o_fcs_pop) begin
			r_fcs <= i_fcs;
		end
	end

	// ------------------------------
	// registered RMII outputs
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_txen <= 1'b0;
			r_txd  <= 2'b00;
		end else begin
			r_txen <= w_on_wire;
			// idle and gap select byte zero
			r_txd  <= w_cur_byte[{r_phase, 1'b0} +: 2];
		end
	end

	assign o_rmii_txen = r_txen;
	assign o_rmii_txd  = r_txd;

endmodule

//--- design/rmii_mac_tx_top.sv
/*
 * RMII MAC transmit top level
 *   - frame fifo and FCS generator fed from the same write strobe
 *   - serializer merges their outputs onto the RMII lines
 */
`timescale 1ns/1ps

module rmii_mac_tx_top #(
	parameter int FIFO_DEPTH = 2048,
	parameter int FCS_DEPTH  = 4
) (
	input  logic       i_clk,
	input  logic       i_rst_n,

	// host byte stream
	input  logic       i_tx_vld,
	input  logic       i_tx_sop,
	input  logic       i_tx_eop,
	input  logic [7:0] i_tx_dat,

	// RMII transmit
	output logic       o_rmii_txen,
	output logic [1:0] o_rmii_txd,

	output logic       o_tx_overflow
);

	mac_pkg::mac_byte_t w_wr_byte;
	mac_pkg::mac_byte_t w_rd_byte;
	logic               w_rd_en;
	logic               w_frame_ready;
	logic [31:0]        w_fcs;
	logic               w_fcs_pop;

	// tag bytes on the way in
	assign w_wr_byte = '{sop: i_tx_sop, eop: i_tx_eop, data: i_tx_dat};

	// ------------------------------
	// payload buffer
	// ------------------------------
	mac_frame_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_mac_frame_fifo (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_wr_en       (i_tx_vld),
		.i_wr_byte     (w_wr_byte),
		.i_rd_en       (w_rd_en),
		.o_rd_byte     (w_rd_byte),
		.o_frame_ready (w_frame_ready),
		.o_overflow    (o_tx_overflow)
	);

	// CRC sees every written byte, dropped or not
	mac_fcs_gen #(
		.FCS_DEPTH (FCS_DEPTH)
	) u_mac_fcs_gen (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr_en   (i_tx_vld),
		.i_wr_byte (w_wr_byte),
		.i_pop     (w_fcs_pop),
		.o_fcs     (w_fcs)
	);

	// ------------------------------
	// wire side
	// ------------------------------
	rmii_tx_serializer u_rmii_tx_serializer (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_frame_ready (w_frame_ready),
		.i_rd_byte     (w_rd_byte),
		.o_rd_en       (w_rd_en),
		.i_fcs         (w_fcs),
		.o_fcs_pop     (w_fcs_pop),
		.o_rmii_txen   (o_rmii_txen),
		.o_rmii_txd    (o_rmii_txd)
	);

endmodule

//--- sim/tb_rmii_frame_model.svh
/*
 * reference model for the RMII MAC transmit testbench
 *   - bitwise reflected CRC-32 with final inversion
 *   - expected on-wire byte sequence of a frame
 *   - dibit capture process and frame compare task
 */
`ifndef TB_RMII_FRAME_MODEL_SVH
`define TB_RMII_FRAME_MODEL_SVH

	// standard ethernet CRC-32, one bit at a time
	function automatic logic [31:0] ref_crc32(input byte_q_t data);
		logic [31:0] crc;
		logic [7:0]  b;
		crc = 32'hFFFFFFFF;
		foreach (data[k]) begin
			b = data[k];
			for (int n = 0; n < 8; n++) begin
				if (crc[0] != b[n]) begin
					crc = {1'b0, crc[31:1]} ^ 32'hEDB88320;
				end else begin
					crc = {1'b0, crc[31:1]};
				end
			end
		end
		return ~crc;
	endfunction

	// preamble, sfd, payload, fcs lsb byte first
	function automatic byte_q_t expected_frame(input byte_q_t payload);
		byte_q_t     q;
		logic [31:0] fcs;
		fcs = ref_crc32(payload);
		for (int i = 0; i < 7; i++) begin
			q.push_back(8'h55);
		end
		q.push_back(8'hD5);
		foreach (payload[i]) begin
			q.push_back(payload[i]);
		end
		for (int i = 0; i < 4; i++) begin
			q.push_back(fcs[8*i +: 8]);
		end
		return q;
	endfunction

	// ------------------------------
	// wire capture
	// ------------------------------
	// samples mid-cycle, away from the output register edge
	task automatic capture_dibits();
		logic [7:0] shreg;
		logic       prev_txen;
		logic       seen_frame;
		int         dibits;
		int         nbytes;
		int         high_clks;
		int         low_clks;
		shreg      = 8'h00;
		prev_txen  = 1'b0;
		seen_frame = 1'b0;
		dibits     = 0;
		nbytes     = 0;
		high_clks  = 0;
		low_clks   = 0;
		ovf_cnt    = 0;
		forever begin
			@(negedge i_clk);
			if (o_tx_overflow) begin
				ovf_cnt++;
			end
			if (o_rmii_txen) begin
				// rising txen closes a gap and opens a frame
				if (!prev_txen) begin
					if (seen_frame) begin
						gap_lens.push_back(low_clks);
					end
					dibits    = 0;
					nbytes    = 0;
					high_clks = 0;
				end
				// low pair arrives first
				shreg = {o_rmii_txd, shreg[7:2]};
				dibits++;
				high_clks++;
				if (dibits == 4) begin
					cap_bytes.push_back(shreg);
					nbytes++;
					dibits = 0;
				end
			end else begin
				if (prev_txen) begin
					cap_lens.push_back(nbytes);
					cap_clks.push_back(high_clks);
					seen_frame = 1'b1;
					low_clks   = 0;
				end
				low_clks++;
			end
			prev_txen = o_rmii_txen;
		end
	endtask

	// oldest captured frame against the model
	task automatic compare_frame(input byte_q_t payload);
		byte_q_t    exp;
		int         len;
		int         clks;
		logic [7:0] got;
		exp = expected_frame(payload);
		chk_cnt++;
		assert (cap_lens.size() > 0) else begin
			err_cnt++;
			$display("no captured frame left to compare against");
		end
		if (cap_lens.size() > 0) begin
			len  = cap_lens.pop_front();
			clks = cap_clks.pop_front();
			check_value("frame byte count", 32'(exp.size()), 32'(len));
			check_value("o_rmii_txen high clocks", 32'(4 * exp.size()), 32'(clks));
			for (int i = 0; i < len; i++) begin
				got = cap_bytes.pop_front();
				if (i < exp.size()) begin
					check_value($sformatf("o_rmii_txd byte %0d", i), 32'(exp[i]), 32'(got));
				end
			end
		end
	endtask

`endif

//--- sim/tb_rmii_mac_tx.sv
/*
 * testbench for the RMII MAC transmit path
 *   - clock, reset, watchdog and host stimulus
 *   - directed tests: idle, framing, back-to-back, mid-frame write, overflow
 *   - closing error report
 */
`timescale 1ns/1ps

module tb_rmii_mac_tx;

	typedef logic [7:0] byte_q_t[$];

	// payload lengths of all tests, sets the watchdog budget
	localparam int PAYLOAD_SUM     = 20 + 12 + 27 + 20 + 30 + 25 + 70;
	localparam int FRAME_CNT       = 7;
	// preamble, sfd, fcs and gap add 24 byte times per frame
	localparam int WATCHDOG_CYCLES = 4 * (PAYLOAD_SUM + 24 * FRAME_CNT) + 3000;
	localparam int MIN_GAP_CLKS    = 48;

	logic       i_clk;
	logic       i_rst_n;
	logic       i_tx_vld;
	logic       i_tx_sop;
	logic       i_tx_eop;
	logic [7:0] i_tx_dat;
	logic       o_rmii_txen;
	logic [1:0] o_rmii_txd;
	logic       o_tx_overflow;

	int         err_cnt;
	int         chk_cnt;
	int         ovf_cnt;
	logic [7:0] cap_bytes[$];
	int         cap_lens[$];
	int         cap_clks[$];
	int         gap_lens[$];

	// small buffer so overflow comes quickly
	rmii_mac_tx_top #(
		.FIFO_DEPTH (64),
		.FCS_DEPTH  (4)
	) u_rmii_mac_tx_top (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_tx_vld      (i_tx_vld),
		.i_tx_sop      (i_tx_sop),
		.i_tx_eop      (i_tx_eop),
		.i_tx_dat      (i_tx_dat),
		.o_rmii_txen   (o_rmii_txen),
		.o_rmii_txd    (o_rmii_txd),
		.o_tx_overflow (o_tx_overflow)
	);

	// ------------------------------
	// check helpers
	// ------------------------------
	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		assert (exp == act) else begin
			err_cnt++;
			$display("FAIL %s: expected 0x%0h, got 0x%0h", name, exp, act);
		end
	endtask

	task automatic check_min(input string name, input int min_val, input int act);
		chk_cnt++;
		assert (act >= min_val) else begin
			err_cnt++;
			$display("FAIL %s: expected >= 0x%0h, got 0x%0h", name, min_val, act);
		end
	endtask

	function automatic byte_q_t random_payload(input int len);
		byte_q_t q;
		for (int i = 0; i < len; i++) begin
			q.push_back(8'($urandom));
		end
		return q;
	endfunction

	// one byte per clock, optional release of the bus after eop
	task automatic send_frame(input byte_q_t payload, input bit release_bus);
		foreach (payload[i]) begin
			@(posedge i_clk);
			#1;
			i_tx_vld = 1'b1;
			i_tx_sop = (i == 0);
			i_tx_eop = (i == payload.size() - 1);
			i_tx_dat = payload[i];
		end
		if (release_bus) begin
			@(posedge i_clk);
			#1;
			i_tx_vld = 1'b0;
			i_tx_sop = 1'b0;
			i_tx_eop = 1'b0;
			i_tx_dat = 8'h00;
		end
	endtask

	task automatic wait_for_frames(input int n, input int max_cycles);
		int waited;
		waited = 0;
		while (cap_lens.size() < n && waited < max_cycles) begin
			@(posedge i_clk);
			waited++;
		end
		chk_cnt++;
		assert (cap_lens.size() >= n) else begin
			err_cnt++;
			$display("timed out after %0d cycles waiting for %0d frames", max_cycles, n);
		end
	endtask

	task automatic wait_for_txen(input int max_cycles);
		int waited;
		waited = 0;
		while (!o_rmii_txen && waited < max_cycles) begin
			@(negedge i_clk);
			waited++;
		end
		chk_cnt++;
		assert (o_rmii_txen) else begin
			err_cnt++;
			$display("transmission did not start within %0d cycles", max_cycles);
		end
	endtask

	`include "tb_rmii_frame_model.svh"

	// ------------------------------
	// directed tests
	// ------------------------------
	// known answer for the model itself, ascii 123456789
	task automatic reference_self_check();
		byte_q_t q;
		for (int k = 0; k < 9; k++) begin
			q.push_back(8'(49 + k));
		end
		check_value("reference crc32", 32'hCBF43926, ref_crc32(q));
	endtask

	task automatic idle_after_reset();
		repeat (16) begin
			@(negedge i_clk);
			check_value("o_rmii_txen", 32'h0, 32'(o_rmii_txen));
			check_value("o_rmii_txd", 32'h0, 32'(o_rmii_txd));
			check_value("o_tx_overflow", 32'h0, 32'(o_tx_overflow));
		end
	endtask

	task automatic single_frame();
		byte_q_t pl;
		int      lat;
		logic    up;
		pl = random_payload(20);
		send_frame(pl, 1'b1);
		// eop was sampled on the last edge, count edges up to txen
		lat = 0;
		up  = 1'b0;
		while (!up && lat < 10) begin
			@(posedge i_clk);
			lat++;
			@(negedge i_clk);
			up = o_rmii_txen;
		end
		check_value("o_rmii_txen rise latency", 32'd2, 32'(lat));
		wait_for_frames(1, 400);
		compare_frame(pl);
	endtask

	task automatic back_to_back_frames();
		byte_q_t p0;
		byte_q_t p1;
		byte_q_t p2;
		p0 = random_payload(12);
		p1 = random_payload(27);
		p2 = random_payload(20);
		send_frame(p0, 1'b0);
		send_frame(p1, 1'b0);
		send_frame(p2, 1'b1);
		wait_for_frames(3, 1200);
		compare_frame(p0);
		compare_frame(p1);
		compare_frame(p2);
		// gaps ahead of the second and third frame
		check_min("gap clocks", MIN_GAP_CLKS, gap_lens[gap_lens.size() - 2]);
		check_min("gap clocks", MIN_GAP_CLKS, gap_lens[gap_lens.size() - 1]);
	endtask

	task automatic write_during_tx();
		byte_q_t pa;
		byte_q_t pb;
		pa = random_payload(30);
		pb = random_payload(25);
		send_frame(pa, 1'b1);
		wait_for_txen(200);
		// second frame lands while the first is on the wire
		repeat (40) @(posedge i_clk);
		send_frame(pb, 1'b1);
		wait_for_frames(2, 1000);
		compare_frame(pa);
		compare_frame(pb);
		check_min("gap clocks before second frame", MIN_GAP_CLKS,
		          gap_lens[gap_lens.size() - 1]);
	endtask

	task automatic overflow_drop();
		byte_q_t pl;
		int      base;
		logic    seen_tx;
		pl   = random_payload(70);
		base = ovf_cnt;
		send_frame(pl, 1'b1);
		repeat (4) @(negedge i_clk);
		check_value("o_tx_overflow pulses", 32'd6, 32'(ovf_cnt - base));
		// eop byte was dropped, frame never counts as complete
		seen_tx = 1'b0;
		repeat (100) begin
			@(negedge i_clk);
			if (o_rmii_txen) begin
				seen_tx = 1'b1;
			end
		end
		check_value("o_rmii_txen after dropped eop", 32'h0, 32'(seen_tx));
	endtask

	// ------------------------------
	// clock, capture, watchdog
	// ------------------------------
	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	initial capture_dibits();

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clk);
		$display("watchdog expired after %0d cycles, errors so far: %0d", WATCHDOG_CYCLES, err_cnt);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int unsigned seed_val;
		seed_val = $urandom(32'h3297);
		err_cnt  = 0;
		chk_cnt  = 0;
		i_rst_n  = 1'b0;
		i_tx_vld = 1'b0;
		i_tx_sop = 1'b0;
		i_tx_eop = 1'b0;
		i_tx_dat = 8'h00;
		repeat (2) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;

		reference_self_check();
		idle_after_reset();
		single_frame();
		back_to_back_frames();
		write_during_tx();
		overflow_drop();

		$display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- rmii_mac_tx_top.f
+incdir+sim
design/mac_pkg.sv
design/mac_frame_fifo.sv
design/mac_fcs_gen.sv
design/rmii_tx_serializer.sv
design/rmii_mac_tx_top.sv
sim/tb_rmii_mac_tx.sv

//--- run_sim.sh
#!/bin/sh
# build and run the RMII MAC transmit testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f rmii_mac_tx_top.f \
	--top-module tb_rmii_mac_tx \
	-o tb_rmii_mac_tx

./obj_dir/tb_rmii_mac_tx > "$LOG" 2>&1
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	echo "run_sim: testbench reported failure"
	exit 1
fi

exit 0
